// File: Makefile
SIM := obj_dir/Vtb_spi_master

all: run

$(SIM): spi_master.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert --top-module tb_spi_master -f spi_master.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: spi_apb_regs.sv
`timescale 1ns/1ps
`include "spi_master_settings.svh"

module spi_apb_regs (
    input  logic                    S_CHAR_GO,
    input  logic                    S_RESETN,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  spi_reg_pkg::apb_addr_t  paddr,
    input  spi_reg_pkg::apb_data_t  pwdata,
    output spi_reg_pkg::apb_data_t  prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic                    busy,
    input  logic                    xfer_done,
    input  spi_link_pkg::spi_char_t rx_char,
    output logic                    start,
    output logic                    enable,
    output logic                    cpol,
    output logic                    cpha,
    output logic                    rev,
    output logic                    loop,
    output spi_reg_pkg::char_len_t  char_len,
    output spi_link_pkg::divider_t  divider,
    output spi_link_pkg::spi_char_t tx_char,
    output logic                    irq
);
    import spi_reg_pkg::*;

    logic      access;
    logic      wr_ok;
    logic      hit;
    logic      go_req;
    logic      reject;
    logic      irq_en;
    logic      done;
    apb_data_t ctrl_rd;

    assign access = psel & penable;
    assign go_req = (paddr == `SPI_REG_CTRL) & pwdata[`SPI_CTRL_GO];
    assign reject = busy & pwrite & (go_req | (paddr == `SPI_REG_TX));    // no queueing
    assign wr_ok  = access & pwrite & hit & ~reject;

    always_comb begin
        case (paddr)
            `SPI_REG_CTRL, `SPI_REG_DIV, `SPI_REG_TX, `SPI_REG_RX, `SPI_REG_STAT: hit = 1'b1;
            default: hit = 1'b0;
        endcase
    end

    assign pready  = 1'b1;
    assign pslverr = access & (~hit | reject);
    assign start   = wr_ok & go_req & pwdata[`SPI_CTRL_ENABLE];  // enable may come in same write
    assign irq     = done & irq_en;

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            enable   <= 1'b0;
            cpol     <= 1'b0;
            cpha     <= 1'b0;
            rev      <= 1'b0;
            loop     <= 1'b0;
            irq_en   <= 1'b0;
            char_len <= '1;
            divider  <= '0;
            done     <= 1'b0;
        end else begin
            if (wr_ok && paddr == `SPI_REG_CTRL) begin
                enable   <= pwdata[`SPI_CTRL_ENABLE];
                cpol     <= pwdata[`SPI_CTRL_CPOL];
                cpha     <= pwdata[`SPI_CTRL_CPHA];
                rev      <= pwdata[`SPI_CTRL_REV];
                loop     <= pwdata[`SPI_CTRL_LOOP];
                irq_en   <= pwdata[`SPI_CTRL_IRQ_EN];
                char_len <= pwdata[`SPI_CTRL_LEN_LO +: $bits(char_len_t)];
            end
            if (wr_ok && paddr == `SPI_REG_DIV)
                divider <= pwdata[`SPI_DIV_NBITS-1:0];
            if (xfer_done)
                done <= 1'b1;   // completion wins over a clear
            else if (wr_ok && paddr == `SPI_REG_STAT && pwdata[`SPI_STAT_DONE])
                done <= 1'b0;
        end
    end

    always_ff @(posedge S_CHAR_GO) begin
        if (wr_ok && paddr == `SPI_REG_TX)
            tx_char <= pwdata;
    end

    always_comb begin
        ctrl_rd = '0;
        ctrl_rd[`SPI_CTRL_ENABLE] = enable;
        ctrl_rd[`SPI_CTRL_CPOL]   = cpol;
        ctrl_rd[`SPI_CTRL_CPHA]   = cpha;
        ctrl_rd[`SPI_CTRL_REV]    = rev;
        ctrl_rd[`SPI_CTRL_LOOP]   = loop;
        ctrl_rd[`SPI_CTRL_IRQ_EN] = irq_en;
        ctrl_rd[`SPI_CTRL_LEN_LO +: $bits(char_len_t)] = char_len;
    end

    always_comb begin
        case (paddr)
            `SPI_REG_CTRL: prdata = ctrl_rd;
            `SPI_REG_DIV:  prdata = apb_data_t'(divider);
            `SPI_REG_TX:   prdata = tx_char;
            `SPI_REG_RX:   prdata = rx_char;
            `SPI_REG_STAT: prdata = apb_data_t'({done, busy});
            default:       prdata = '0;
        endcase
    end

    a_start_busy: assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        start |=> busy);

endmodule

// File: spi_char_ctrl.sv
`timescale 1ns/1ps

module spi_char_ctrl (
    input  logic                   S_CHAR_GO,
    input  logic                   S_RESETN,
    input  logic                   start,
    input  logic                   cpha,
    input  spi_reg_pkg::char_len_t char_len,
    input  logic                   tick,
    input  logic                   lead_edge,
    input  logic                   trail_edge,
    output logic                   run,
    output logic                   sck_en,
    output logic                   load,
    output logic                   drive_stb,
    output logic                   sample_stb,
    output logic                   spi_cs_n,
    output logic                   busy,
    output logic                   xfer_done
);
    import spi_link_pkg::*;

    xfer_state_e state;
    bit_cnt_t    bit_cnt;       // trailing edges so far
    bit_cnt_t    n_bits;
    logic        last_trail;

    assign n_bits     = bit_cnt_t'(char_len) + bit_cnt_t'(1);
    assign last_trail = trail_edge & (bit_cnt + bit_cnt_t'(1) == n_bits);

    assign busy   = (state != IDLE);
    assign run    = busy;       // divider counts for the whole frame
    assign sck_en = (state == SHIFT);

    // bit 0 is already on mosi from load, so one drive edge per mode is skipped
    assign sample_stb = cpha ? trail_edge : lead_edge;
    assign drive_stb  = cpha ? (lead_edge & (bit_cnt != '0)) : (trail_edge & ~last_trail);

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state     <= IDLE;
            bit_cnt   <= '0;
            spi_cs_n  <= 1'b1;
            load      <= 1'b0;
            xfer_done <= 1'b0;
        end else begin
            load      <= start;     // config regs settle one cycle after the go write
            xfer_done <= 1'b0;
            case (state)
                IDLE: if (start) begin
                    state    <= SETUP;
                    spi_cs_n <= 1'b0;
                    bit_cnt  <= '0;
                end
                SETUP: if (tick)
                    state <= SHIFT;
                SHIFT: if (trail_edge) begin
                    bit_cnt <= bit_cnt + bit_cnt_t'(1);
                    if (last_trail)
                        state <= HOLD;
                end
                HOLD: if (tick) begin
                    state     <= IDLE;
                    spi_cs_n  <= 1'b1;
                    xfer_done <= 1'b1;
                end
            endcase
        end
    end

    a_strobe_excl: assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        !(drive_stb && sample_stb));

    a_cs_busy: assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        spi_cs_n == !busy);

endmodule

// File: spi_clk_gen.sv
`timescale 1ns/1ps

module spi_clk_gen (
    input  logic                   S_CHAR_GO,
    input  logic                   S_RESETN,
    input  logic                   run,
    input  logic                   sck_en,
    input  logic                   cpol,
    input  spi_link_pkg::divider_t divider,
    output logic                   spi_sck,
    output logic                   tick,
    output logic                   lead_edge,
    output logic                   trail_edge
);
    import spi_link_pkg::*;

    divider_t cnt;
    logic     sck_q;

    // strobes mark the cycle whose closing clock edge moves sck
    assign tick       = run & (cnt == '0);
    assign lead_edge  = tick & sck_en & (sck_q == cpol);
    assign trail_edge = tick & sck_en & (sck_q != cpol);
    assign spi_sck    = sck_en ? sck_q : cpol;    // rest level outside shift

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            cnt   <= '0;
            sck_q <= 1'b0;
        end else begin
            if (!run || tick)
                cnt <= divider;     // half period is divider+1 clocks
            else
                cnt <= cnt - divider_t'(1);
            if (!sck_en)
                sck_q <= cpol;
            else if (tick)
                sck_q <= ~sck_q;
        end
    end

endmodule

// File: spi_link_pkg.sv
`include "spi_master_settings.svh"

package spi_link_pkg;

    typedef logic [`SPI_CHAR_NBITS-1:0] spi_char_t;
    typedef logic [$clog2(`SPI_CHAR_NBITS):0] bit_cnt_t;   // holds 0..32
    typedef logic [`SPI_DIV_NBITS-1:0] divider_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,      // cs low, sck at rest
        SHIFT,
        HOLD        // last half period before cs rises
    } xfer_state_e;

endpackage

// File: spi_master.f
+incdir+.
spi_reg_pkg.sv
spi_link_pkg.sv
spi_apb_regs.sv
spi_char_ctrl.sv
spi_clk_gen.sv
spi_trx_char.sv
spi_master_top.sv
tb_clk_rst.sv
tb_spi_master.sv

// File: spi_master_settings.svh
`ifndef SPI_MASTER_SETTINGS_SVH
`define SPI_MASTER_SETTINGS_SVH

`define SPI_CHAR_NBITS  32      // widest character
`define SPI_DIV_NBITS   8
`define SPI_APB_AW      5       // byte offsets up to 0x1f

`define SPI_REG_CTRL    5'h00
`define SPI_REG_DIV     5'h04
`define SPI_REG_TX      5'h08
`define SPI_REG_RX      5'h0c
`define SPI_REG_STAT    5'h10

`define SPI_CTRL_ENABLE 0
`define SPI_CTRL_CPOL   1
`define SPI_CTRL_CPHA   2
`define SPI_CTRL_REV    3       // msb first
`define SPI_CTRL_LOOP   4
`define SPI_CTRL_IRQ_EN 5
`define SPI_CTRL_GO     6       // write-only strobe
`define SPI_CTRL_LEN_LO 8       // char_len in 12:8

`define SPI_STAT_BUSY   0
`define SPI_STAT_DONE   1       // write 1 to clear

`endif

// File: spi_master_top.sv
`timescale 1ns/1ps

module spi_master_top (
    input  logic                   S_CHAR_GO,
    input  logic                   S_RESETN,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  spi_reg_pkg::apb_addr_t paddr,
    input  spi_reg_pkg::apb_data_t pwdata,
    output spi_reg_pkg::apb_data_t prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   spi_cs_n,
    output logic                   spi_sck,
    output logic                   spi_mosi,
    input  logic                   spi_miso,
    output logic                   irq
);
    import spi_reg_pkg::*;
    import spi_link_pkg::*;

    logic      start;
    logic      cpol;
    logic      cpha;
    logic      rev;
    logic      loop;
    char_len_t char_len;
    divider_t  divider;
    spi_char_t tx_char;
    spi_char_t rx_char;
    logic      busy;
    logic      xfer_done;
    logic      run;
    logic      sck_en;
    logic      tick;
    logic      lead_edge;
    logic      trail_edge;
    logic      load;
    logic      drive_stb;
    logic      sample_stb;

    spi_apb_regs regs_i (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .busy      (busy),
        .xfer_done (xfer_done),
        .rx_char   (rx_char),
        .start     (start),
        .enable    (),              // readback only
        .cpol      (cpol),
        .cpha      (cpha),
        .rev       (rev),
        .loop      (loop),
        .char_len  (char_len),
        .divider   (divider),
        .tx_char   (tx_char),
        .irq       (irq)
    );

    spi_char_ctrl ctrl_i (
        .S_CHAR_GO  (S_CHAR_GO),
        .S_RESETN   (S_RESETN),
        .start      (start),
        .cpha       (cpha),
        .char_len   (char_len),
        .tick       (tick),
        .lead_edge  (lead_edge),
        .trail_edge (trail_edge),
        .run        (run),
        .sck_en     (sck_en),
        .load       (load),
        .drive_stb  (drive_stb),
        .sample_stb (sample_stb),
        .spi_cs_n   (spi_cs_n),
        .busy       (busy),
        .xfer_done  (xfer_done)
    );

    spi_clk_gen clk_gen_i (
        .S_CHAR_GO  (S_CHAR_GO),
        .S_RESETN   (S_RESETN),
        .run        (run),
        .sck_en     (sck_en),
        .cpol       (cpol),
        .divider    (divider),
        .spi_sck    (spi_sck),
        .tick       (tick),
        .lead_edge  (lead_edge),
        .trail_edge (trail_edge)
    );

    spi_trx_char trx_i (
        .S_CHAR_GO  (S_CHAR_GO),
        .S_RESETN   (S_RESETN),
        .load       (load),
        .drive_stb  (drive_stb),
        .sample_stb (sample_stb),
        .rev        (rev),
        .loop       (loop),
        .char_len   (char_len),
        .tx_char    (tx_char),
        .spi_miso   (spi_miso),
        .spi_mosi   (spi_mosi),
        .rx_char    (rx_char)
    );

endmodule

// File: spi_reg_pkg.sv
`include "spi_master_settings.svh"

package spi_reg_pkg;

    typedef logic [`SPI_APB_AW-1:0] apb_addr_t;    // byte offset
    typedef logic [31:0] apb_data_t;

    // length minus one, 0 means a single bit
    typedef logic [$clog2(`SPI_CHAR_NBITS)-1:0] char_len_t;

endpackage

// File: spi_trx_char.sv
`timescale 1ns/1ps

module spi_trx_char (
    input  logic                    S_CHAR_GO,
    input  logic                    S_RESETN,
    input  logic                    load,
    input  logic                    drive_stb,
    input  logic                    sample_stb,
    input  logic                    rev,
    input  logic                    loop,
    input  spi_reg_pkg::char_len_t  char_len,
    input  spi_link_pkg::spi_char_t tx_char,
    input  logic                    spi_miso,
    output logic                    spi_mosi,
    output spi_link_pkg::spi_char_t rx_char
);
    import spi_reg_pkg::*;
    import spi_link_pkg::*;

    spi_char_t tx_buf;      // frozen copy for the whole frame
    spi_char_t rx_buf;
    char_len_t idx;
    char_len_t idx_next;
    char_len_t first_idx;
    logic      rx_bit;
    logic      last_bit;

    assign first_idx = rev ? char_len : '0;
    assign idx_next  = rev ? (idx - char_len_t'(1)) : (idx + char_len_t'(1));
    assign last_bit  = rev ? (idx == '0) : (idx == char_len);
    assign rx_bit    = loop ? spi_mosi : spi_miso;

    always_ff @(posedge S_CHAR_GO) begin
        if (load) begin
            tx_buf <= tx_char;
            rx_buf <= '0;   // bits above the character stay zero
        end else if (sample_stb) begin
            rx_buf[idx] <= rx_bit;
        end
    end

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            idx      <= '0;
            spi_mosi <= 1'b1;
            rx_char  <= '1;
        end else begin
            if (load) begin
                idx      <= first_idx;
                spi_mosi <= tx_char[first_idx];
            end else if (drive_stb) begin
                idx      <= idx_next;
                spi_mosi <= tx_buf[idx_next];
            end
            // final bit merged directly, rx_buf not yet updated
            if (sample_stb && last_bit)
                rx_char <= rx_buf | (spi_char_t'(rx_bit) << idx);
        end
    end

endmodule

// File: tb_clk_rst.sv
`timescale 1ns/1ps

module tb_clk_rst (
    output logic S_CHAR_GO,
    output logic S_RESETN
);
    initial begin
        S_CHAR_GO = 1'b0;
        forever #10 S_CHAR_GO = ~S_CHAR_GO;     // 20 ns period
    end

    initial begin
        S_RESETN = 1'b0;
        repeat (3) @(posedge S_CHAR_GO);
        @(negedge S_CHAR_GO);
        S_RESETN = 1'b1;
    end

endmodule

// File: tb_spi_master.sv
`timescale 1ns/1ps
`include "spi_master_settings.svh"

module tb_spi_master;
    import spi_reg_pkg::*;

    localparam int BUSY_LIMIT = 4000;   // cycles

    logic        S_CHAR_GO;
    logic        S_RESETN;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    logic        spi_cs_n;
    logic        spi_sck;
    logic        spi_mosi;
    logic        spi_miso = 1'b0;
    logic        irq;

    integer      seed;
    logic        model_cpol;    // cpol as last accepted through CTRL
    logic        s_cpha;
    logic        s_rev;
    int          s_n;
    logic [31:0] slave_char;
    logic [31:0] slave_rx;
    int          drive_k;
    int          sample_k;
    int          lead_cnt;
    logic        prev_sck;
    logic        prev_cs_n;

    tb_clk_rst clk_rst_i (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN)
    );

    spi_master_top dut_i (.*);

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s expected %h got %h", $time, what, expected, actual);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] len_mask(input int nb);
        logic [63:0] m;
        m = (64'd1 << nb) - 64'd1;
        return m[31:0];
    endfunction

    function automatic int bit_pos(input int k);
        return s_rev ? (s_n - 1 - k) : k;
    endfunction

    // starts and ends on a falling edge
    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge S_CHAR_GO);
        penable = 1'b1;
        #1;
        check_value("pready", 32'd1, 32'(pready));
        rdata = prdata;
        err   = pslverr;
        if (wr && addr == `SPI_REG_CTRL && !pslverr)
            model_cpol = wdata[1];
        @(negedge S_CHAR_GO);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
        apb_data_t rd;
        logic      err;
        apb_access(1'b1, addr, data, rd, err);
        check_value("pslverr on write", 32'(exp_err), 32'(err));
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_value("pslverr on read", 32'd0, 32'(err));
    endtask

    task automatic wait_idle();
        apb_data_t st;
        int        cycles;
        cycles = 0;
        st     = 32'd1;
        while (st[0] && cycles <= BUSY_LIMIT) begin
            apb_read(`SPI_REG_STAT, st);
            cycles += 2;
        end
        if (st[0]) begin
            $display("Timeout: busy never fell within %0d cycles", BUSY_LIMIT);
            stop_with_failure();
        end
    endtask

    task automatic slave_drive();
        if (drive_k < s_n) begin
            spi_miso = slave_char[bit_pos(drive_k)];
            drive_k++;
        end
    endtask

    task automatic slave_capture();
        if (sample_k < s_n) begin
            slave_rx[bit_pos(sample_k)] = spi_mosi;
            sample_k++;
        end
    endtask

    // slave model and bus monitor that see sck edges half a cycle late
    always @(negedge S_CHAR_GO) begin
        if (S_RESETN) begin
            if (spi_cs_n) begin
                check_value("sck idle level", 32'(model_cpol), 32'(spi_sck));
            end else if (prev_cs_n) begin
                slave_rx = '0;
                drive_k  = 0;
                sample_k = 0;
                lead_cnt = 0;
                if (!s_cpha)
                    slave_drive();  // first bit out before the first edge
            end else if (spi_sck !== prev_sck) begin
                if (spi_sck !== model_cpol) begin
                    lead_cnt++;
                    if (s_cpha) slave_drive(); else slave_capture();
                end else begin
                    if (s_cpha) slave_capture(); else slave_drive();
                end
            end
        end
        prev_sck  = spi_sck;
        prev_cs_n = spi_cs_n;
    end

    task automatic run_transfer(input logic cpol, input logic cpha, input logic rev,
                                input logic loop, input logic irq_en,
                                input logic [4:0] len_m1, input logic [7:0] div,
                                input logic [31:0] tx, input logic [31:0] sl,
                                input logic collide);
        apb_data_t   cfg;
        apb_data_t   d;
        logic [31:0] mask;
        int          nb;
        nb   = int'(len_m1) + 1;
        mask = len_mask(nb);
        cfg  = {19'd0, len_m1, 1'b0, 1'b0, irq_en, loop, rev, cpha, cpol, 1'b1};
        apb_write(`SPI_REG_DIV, 32'(div), 1'b0);
        apb_write(`SPI_REG_TX, tx, 1'b0);
        apb_write(`SPI_REG_CTRL, cfg, 1'b0);    // settle sck rest level first
        apb_read(`SPI_REG_CTRL, d);
        check_value("CTRL readback", cfg, d);
        s_cpha     = cpha;
        s_rev      = rev;
        s_n        = nb;
        slave_char = sl;
        apb_write(`SPI_REG_CTRL, cfg | 32'h40, 1'b0);
        if (collide) begin
            apb_write(`SPI_REG_TX, ~tx, 1'b1);
            apb_write(`SPI_REG_CTRL, cfg | 32'h40, 1'b1);
            apb_read(`SPI_REG_TX, d);
            check_value("TX after rejected write", tx, d);
        end
        wait_idle();
        check_value("bits seen by slave", tx & mask, slave_rx);
        check_value("sck leading edges", 32'(nb), 32'(lead_cnt));
        apb_read(`SPI_REG_RX, d);
        check_value("RX register", loop ? (tx & mask) : (sl & mask), d);
        apb_read(`SPI_REG_STAT, d);
        check_value("STATUS after transfer", 32'h2, d);
        check_value("irq after transfer", 32'(irq_en), 32'(irq));
        apb_write(`SPI_REG_STAT, 32'h2, 1'b0);
        apb_read(`SPI_REG_STAT, d);
        check_value("STATUS after clear", 32'h0, d);
        check_value("irq after clear", 32'd0, 32'(irq));
    endtask

    initial begin
        int          i;
        int          n;
        logic [31:0] r;
        logic [31:0] tx;
        logic [31:0] sl;
        apb_data_t   d;
        logic        err;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        model_cpol = 1'b0;
        s_cpha     = 1'b0;
        s_rev      = 1'b0;
        s_n        = 1;
        slave_char = '0;
        seed       = 32'h28c1;
        n = 0;
        while (S_RESETN !== 1'b1 && n <= 20) begin
            @(negedge S_CHAR_GO);
            n++;
        end
        if (S_RESETN !== 1'b1) begin
            $display("Reset was never released");
            stop_with_failure();
        end
        @(negedge S_CHAR_GO);

        check_value("cs_n after reset", 32'd1, 32'(spi_cs_n));
        check_value("sck after reset", 32'd0, 32'(spi_sck));
        check_value("mosi after reset", 32'd1, 32'(spi_mosi));
        check_value("irq after reset", 32'd0, 32'(irq));
        apb_read(`SPI_REG_STAT, d);
        check_value("STATUS after reset", 32'h0, d);
        apb_read(`SPI_REG_RX, d);
        check_value("RX after reset", 32'hffff_ffff, d);

        for (i = 0; i < 40; i++) begin
            r  = $random(seed);
            tx = $random(seed);
            sl = $random(seed);
            run_transfer(r[0], r[1], r[2], 1'b0, r[3], r[8:4], {5'd0, r[11:9]}, tx, sl, 1'b0);
        end

        for (i = 0; i < 8; i++) begin
            r  = $random(seed);
            tx = $random(seed);
            sl = $random(seed);
            run_transfer(r[0], r[1], r[2], 1'b1, r[3], r[8:4], {5'd0, r[11:9]}, tx, sl, 1'b0);
        end

        tx = $random(seed);
        sl = $random(seed);
        run_transfer(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 5'd15, 8'd3, tx, sl, 1'b1);

        apb_access(1'b0, 5'h14, '0, d, err);
        check_value("pslverr on unmapped read", 32'd1, 32'(err));
        apb_access(1'b1, 5'h1c, 32'h1234_5678, d, err);
        check_value("pslverr on unmapped write", 32'd1, 32'(err));

        $display("Finished with no errors");
        $finish;
    end

endmodule
